// File: Makefile
VERILATOR ?= verilator
TOP       ?= sodor_core_tb
FILELIST  ?= sodor_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  sodor_pkg::exe_t exe_i,
    output sodor_pkg::fwd_t result_o
);
    import sodor_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      result;
    logic [4:0] shamt;

    assign op_a  = exe_i.rs1_data;
    assign op_b  = exe_i.use_imm ? exe_i.imm : exe_i.rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (exe_i.alu_op)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            default:  result = '0;
        endcase
    end

    // only a live alu instruction with a real destination forwards
    always_comb begin
        result_o.valid = exe_i.valid && exe_i.is_alu && (exe_i.rd != '0);
        result_o.rd    = exe_i.rd;
        result_o.data  = result;
    end

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  sodor_pkg::exe_t      exe_i,
    output sodor_pkg::redirect_t redirect_o
);
    import sodor_pkg::*;

    word_t rs1;
    word_t rs2;
    logic  cond;

    assign rs1 = exe_i.rs1_data;
    assign rs2 = exe_i.rs2_data;

    always_comb begin
        case (exe_i.funct3)
            F3_BEQ:  cond = (rs1 == rs2);
            F3_BNE:  cond = (rs1 != rs2);
            F3_BLT:  cond = ($signed(rs1) < $signed(rs2));
            F3_BGE:  cond = ($signed(rs1) >= $signed(rs2));
            F3_BLTU: cond = (rs1 < rs2);
            F3_BGEU: cond = (rs1 >= rs2);
            // 010 and 011 are not branch encodings
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        redirect_o.taken  = exe_i.valid && exe_i.is_branch && cond;
        redirect_o.target = exe_i.pc + exe_i.br_offset;
    end

endmodule

`default_nettype wire

// File: front_end.sv
`timescale 1ns/1ps
`default_nettype none

module front_end (
    input  logic                 clk,
    input  logic                 reset,
    input  sodor_pkg::inst_t     imem_data_i,
    output sodor_pkg::word_t     pc_o,
    input  sodor_pkg::redirect_t redirect_i,
    input  sodor_pkg::fwd_t      exe_fwd_i,
    input  sodor_pkg::fwd_t      mem_fwd_i,
    input  sodor_pkg::fwd_t      wr_i,
    output sodor_pkg::exe_t      exe_o
);
    import sodor_pkg::*;

    word_t      pc_q;
    logic       if_valid_q;
    inst_t      if_inst_q;
    word_t      if_pc_q;
    exe_t       exe_d;
    exe_t       exe_q;
    logic [6:0] opcode;
    logic [6:0] funct7;
    reg_addr_t  rs1_addr;
    reg_addr_t  rs2_addr;
    word_t      rf_rs1;
    word_t      rf_rs2;
    logic       is_alu_i;
    logic       is_alu_r;
    alu_op_t    alu_op;

    // newest producer wins, the register file covers writeback
    function automatic word_t bypass(input reg_addr_t addr, input word_t rf_data);
        word_t value;
        if (exe_fwd_i.valid && (exe_fwd_i.rd == addr)) begin
            value = exe_fwd_i.data;
        end else if (mem_fwd_i.valid && (mem_fwd_i.rd == addr)) begin
            value = mem_fwd_i.data;
        end else begin
            value = rf_data;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q <= RESET_PC;
        end else if (redirect_i.taken) begin
            pc_q <= redirect_i.target;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    // fetch register, a taken branch turns it into a bubble
    always_ff @(posedge clk) begin
        if_valid_q <= !(reset || redirect_i.taken);
        if_inst_q  <= redirect_i.taken ? NOP_INST : imem_data_i;
        if_pc_q    <= pc_q;
    end

    assign opcode   = if_inst_q[6:0];
    assign funct7   = if_inst_q[31:25];
    assign rs1_addr = if_inst_q[19:15];
    assign rs2_addr = if_inst_q[24:20];
    assign is_alu_i = (opcode == OP_ALU_I);
    assign is_alu_r = (opcode == OP_ALU_R);

    regfile u_regfile (
        .clk        (clk),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rf_rs1),
        .rs2_data_o (rf_rs2),
        .wr_i       (wr_i)
    );

    always_comb begin
        case (if_inst_q[14:12])
            3'b000:  alu_op = (is_alu_r && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            // srai carries the same funct7 bit in imm[10]
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        exe_d.valid     = if_valid_q;
        exe_d.pc        = if_pc_q;
        exe_d.funct3    = if_inst_q[14:12];
        exe_d.alu_op    = alu_op;
        exe_d.is_alu    = is_alu_i || is_alu_r;
        exe_d.is_branch = (opcode == OP_BRANCH);
        exe_d.use_imm   = is_alu_i;
        exe_d.rd        = if_inst_q[11:7];
        exe_d.rs1_data  = bypass(rs1_addr, rf_rs1);
        exe_d.rs2_data  = bypass(rs2_addr, rf_rs2);
        exe_d.imm       = {{20{if_inst_q[31]}}, if_inst_q[31:20]};
        exe_d.br_offset = {{19{if_inst_q[31]}}, if_inst_q[31], if_inst_q[7],
                           if_inst_q[30:25], if_inst_q[11:8], 1'b0};
    end

    // the instruction in decode is killed by a taken branch too
    always_ff @(posedge clk) begin
        exe_q <= exe_d;
        if (reset || redirect_i.taken) begin
            exe_q.valid <= 1'b0;
        end
    end

    assign pc_o  = pc_q;
    assign exe_o = exe_q;

endmodule

`default_nettype wire

// File: regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                 clk,
    input  sodor_pkg::reg_addr_t rs1_addr_i,
    input  sodor_pkg::reg_addr_t rs2_addr_i,
    output sodor_pkg::word_t     rs1_data_o,
    output sodor_pkg::word_t     rs2_data_o,
    input  sodor_pkg::fwd_t      wr_i
);
    import sodor_pkg::*;

    word_t regs [NUM_REGS];

    // x0 reads zero and a same-cycle write passes straight through
    function automatic word_t read_port(input reg_addr_t addr, input word_t stored,
                                        input fwd_t wr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wr.valid && (wr.rd == addr)) begin
            value = wr.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_i.valid && (wr_i.rd != '0)) begin
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    assign rs1_data_o = read_port(rs1_addr_i, regs[rs1_addr_i], wr_i);
    assign rs2_data_o = read_port(rs2_addr_i, regs[rs2_addr_i], wr_i);

endmodule

`default_nettype wire

// File: sodor_core.f
sodor_pkg.sv
regfile.sv
front_end.sv
alu_unit.sv
branch_unit.sv
writeback_stage.sv
sodor_core.sv
tb_clock_gen.sv
sodor_core_assertions.sv
sodor_core_tb.sv

// File: sodor_core.sv
`timescale 1ns/1ps
`default_nettype none

module sodor_core (
    input  logic               clk,
    input  logic               reset,
    input  sodor_pkg::inst_t   imem_data_i,
    output sodor_pkg::word_t   pc_o,
    output sodor_pkg::retire_t retire_o
);
    import sodor_pkg::*;

    // decode-to-execute register
    exe_t      exe;

    // execute stage outcomes
    fwd_t      exe_fwd;
    redirect_t redirect;

    // memory-stage bypass and register write
    fwd_t      mem_fwd;
    fwd_t      wr;

    front_end u_front_end (
        .clk         (clk),
        .reset       (reset),
        .imem_data_i (imem_data_i),
        .pc_o        (pc_o),
        .redirect_i  (redirect),
        .exe_fwd_i   (exe_fwd),
        .mem_fwd_i   (mem_fwd),
        .wr_i        (wr),
        .exe_o       (exe)
    );

    alu_unit u_alu_unit (
        .exe_i    (exe),
        .result_o (exe_fwd)
    );

    branch_unit u_branch_unit (
        .exe_i      (exe),
        .redirect_o (redirect)
    );

    writeback_stage u_writeback_stage (
        .clk        (clk),
        .reset      (reset),
        .exe_i      (exe),
        .alu_i      (exe_fwd),
        .redirect_i (redirect),
        .mem_fwd_o  (mem_fwd),
        .wr_o       (wr),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

// File: sodor_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sodor_core_assertions (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  sodor_pkg::word_t     pc_i,
    input  sodor_pkg::redirect_t redirect_i,
    input  sodor_pkg::retire_t   retire_i
);
    import sodor_pkg::*;

    logic [2:0] cycles_q;
    logic       taken;
    word_t      target;

    assign taken  = redirect_i.taken;
    assign target = redirect_i.target;

    // cycles since reset, saturating at four
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cycles_q <= '0;
        end else if (cycles_q != 3'd4) begin
            cycles_q <= cycles_q + 3'd1;
        end
    end

    // the pipeline needs four cycles to fill
    a_no_early_retire: assert property (@(posedge clk_i) disable iff (reset_i)
        (cycles_q < 3'd4) |-> !retire_i.valid)
        else $error("retire within four cycles of reset");

    a_no_x0_write: assert property (@(posedge clk_i) disable iff (reset_i)
        (retire_i.valid && retire_i.writes_rd) |-> (retire_i.rd != '0))
        else $error("retire writes x0");

    // sequential fetch unless a branch was taken in execute
    a_pc_step: assert property (@(posedge clk_i) disable iff (reset_i)
        (!$past(reset_i) && !$past(taken)) |-> (pc_i == $past(pc_i) + 32'd4))
        else $error("pc did not advance by four");

    a_pc_redirect: assert property (@(posedge clk_i) disable iff (reset_i)
        (!$past(reset_i) && $past(taken)) |-> (pc_i == $past(target)))
        else $error("pc did not follow the branch target");

endmodule

bind sodor_core sodor_core_assertions u_assertions (
    .clk_i      (clk),
    .reset_i    (reset),
    .pc_i       (pc_o),
    .redirect_i (redirect),
    .retire_i   (retire_o)
);

`default_nettype wire

// File: sodor_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sodor_core_tb;
    import sodor_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RETIRES  = 2000;
    localparam int MEM_WORDS    = 64;

    logic        clk;
    logic        reset;
    inst_t       imem_data;
    word_t       pc;
    retire_t     retire;
    inst_t       imem [MEM_WORDS];
    retire_t     expected [$];
    logic [31:0] lcg_state;
    int          taken_count;
    logic        model_ready;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    sodor_core u_dut (
        .clk         (clk),
        .reset       (reset),
        .imem_data_i (imem_data),
        .pc_o        (pc),
        .retire_o    (retire)
    );

    // combinational instruction port that wraps every 64 words
    assign imem_data = imem[pc[7:2]];

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [15:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    function automatic int pick(input int n);
        return int'(next_random()) % n;
    endfunction

    function automatic inst_t itype_word(input logic [11:0] imm, input reg_addr_t rs1,
                                         input logic [2:0] f3, input reg_addr_t rd,
                                         input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic inst_t rtype_word(input logic [6:0] f7, input reg_addr_t rs2,
                                         input reg_addr_t rs1, input logic [2:0] f3,
                                         input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_ALU_R};
    endfunction

    function automatic inst_t branch_word(input logic [12:0] off, input reg_addr_t rs2,
                                          input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    task automatic fill_program();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [12:0] off;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        int          kind;
        int          span;
        // x1..x7 get defined values before anything reads them
        for (int i = 1; i < 8; i++) begin
            imm = 12'(next_random());
            imem[i-1] = itype_word(imm, 5'd0, 3'b000, reg_addr_t'(i), OP_ALU_I);
        end
        for (int i = 7; i < MEM_WORDS; i++) begin
            kind = pick(16);
            rd   = reg_addr_t'(pick(8));
            rs1  = reg_addr_t'(pick(8));
            rs2  = reg_addr_t'(pick(8));
            imm  = 12'(next_random());
            f3   = 3'(pick(8));
            if (kind < 7) begin
                // immediate shifts keep funct7 in the upper immediate bits
                if (f3 == 3'b001) begin
                    imm[11:5] = 7'b0;
                end else if (f3 == 3'b101) begin
                    imm[11:5] = (pick(2) == 1) ? 7'b0100000 : 7'b0;
                end
                imem[i] = itype_word(imm, rs1, f3, rd, OP_ALU_I);
            end else if (kind < 12) begin
                f7 = 7'b0;
                if ((f3 == 3'b000 || f3 == 3'b101) && pick(2) == 1) begin
                    f7 = 7'b0100000;
                end
                imem[i] = rtype_word(f7, rs2, rs1, f3, rd);
            end else if (kind < 15) begin
                span = 2 + pick(29);
                if (pick(2) == 1) begin
                    span = -span;
                end
                off = 13'(span * 4);
                imem[i] = branch_word(off, rs2, rs1, f3);
            end else begin
                // lui is outside the supported set
                imem[i] = itype_word(imm, rs1, f3, rd, 7'b0110111);
            end
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        word_t r;
        case (f3)
            3'b000:  r = alt ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101:  r = alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        logic t;
        case (f3)
            3'b000:  t = (a == b);
            3'b001:  t = (a != b);
            3'b100:  t = ($signed(a) < $signed(b));
            3'b101:  t = ($signed(a) >= $signed(b));
            3'b110:  t = (a < b);
            3'b111:  t = (a >= b);
            default: t = 1'b0;
        endcase
        return t;
    endfunction

    // ISA-level execution of the program with one record per retired instruction
    task automatic run_model();
        word_t      regs [32];
        word_t      mpc;
        word_t      a;
        word_t      b;
        word_t      boff;
        inst_t      inst;
        retire_t    rec;
        logic [2:0] f3;
        logic       alt;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        mpc = RESET_PC;
        taken_count = 0;
        for (int n = 0; n < NUM_RETIRES; n++) begin
            inst = imem[mpc[7:2]];
            f3   = inst[14:12];
            a    = regs[inst[19:15]];
            b    = regs[inst[24:20]];
            rec  = '0;
            rec.valid = 1'b1;
            rec.pc    = mpc;
            rec.rd    = inst[11:7];
            mpc       = mpc + 32'd4;
            if (inst[6:0] == OP_ALU_I || inst[6:0] == OP_ALU_R) begin
                if (inst[6:0] == OP_ALU_I) begin
                    b = {{20{inst[31]}}, inst[31:20]};
                end
                alt = inst[30] && (inst[6:0] == OP_ALU_R || f3 == 3'b101);
                rec.data      = alu_ref(f3, alt, a, b);
                rec.writes_rd = (rec.rd != 5'd0);
                if (rec.writes_rd) begin
                    regs[rec.rd] = rec.data;
                end
            end else if (inst[6:0] == OP_BRANCH) begin
                rec.is_branch = 1'b1;
                rec.taken     = branch_ref(f3, a, b);
                if (rec.taken) begin
                    boff = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
                    mpc  = rec.pc + boff;
                    taken_count++;
                end
            end
            expected.push_back(rec);
        end
    endtask

    task automatic pc_check(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act));
        end
    endtask

    task automatic data_check(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, exp, act));
        end
    endtask

    task automatic rd_check(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected x%0d, actual x%0d", name, exp, act));
        end
    endtask

    task automatic taken_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic retire_check(input int n, input retire_t exp, input retire_t act);
        string tag;
        tag = $sformatf("retire %0d", n);
        pc_check({tag, " pc"}, exp.pc, act.pc);
        flag_check({tag, " is_branch"}, exp.is_branch, act.is_branch);
        taken_check({tag, " taken"}, exp.taken, act.taken);
        flag_check({tag, " writes_rd"}, exp.writes_rd, act.writes_rd);
        if (exp.writes_rd) begin
            rd_check({tag, " rd"}, exp.rd, act.rd);
            data_check({tag, " data"}, exp.data, act.data);
        end
    endtask

    initial begin : stimulus
        int      cycle;
        int      checked;
        retire_t exp;
        lcg_state   = 32'd41;
        model_ready = 1'b0;
        fill_program();
        run_model();
        model_ready = 1'b1;
        cycle   = 0;
        checked = 0;
        while (reset !== 1'b0) begin
            @(negedge clk);
        end
        pc_check("pc after reset", RESET_PC, pc);
        // outputs are sampled mid-cycle away from the rising edge
        while (checked < NUM_RETIRES) begin
            if (retire.valid === 1'b1) begin
                if (cycle < 4) begin
                    abort_run("an instruction retired within four cycles of reset");
                end else begin
                    exp = expected.pop_front();
                    retire_check(checked, exp, retire);
                    checked++;
                end
            end else if (retire.valid !== 1'b0) begin
                abort_run("retire valid is unknown");
            end
            cycle++;
            @(negedge clk);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin : watchdog
        longint limit_ns;
        wait (model_ready === 1'b1);
        // one cycle per retire and two bubbles per taken branch, all doubled
        limit_ns = longint'(RESET_CYCLES + 4 + NUM_RETIRES + 2 * taken_count)
                   * 2 * CLK_PERIOD;
        #(limit_ns);
        abort_run("watchdog timeout, the DUT stopped retiring instructions");
    end

endmodule

`default_nettype wire

// File: sodor_pkg.sv
`default_nettype none

package sodor_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [3:0]      alu_op_t;

    // major opcodes handled by the core, everything else is a no-op
    localparam logic [6:0] OP_ALU_I  = 7'b0010011;
    localparam logic [6:0] OP_ALU_R  = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    // alu operation codes
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SRL  = 4'd3;
    localparam alu_op_t ALU_SRA  = 4'd4;
    localparam alu_op_t ALU_AND  = 4'd5;
    localparam alu_op_t ALU_OR   = 4'd6;
    localparam alu_op_t ALU_XOR  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;

    // branch conditions by funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // addi x0, x0, 0
    localparam inst_t NOP_INST = 32'h0000_0013;
    localparam word_t RESET_PC = '0;

    // decode-to-execute register
    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [2:0] funct3;
        alu_op_t    alu_op;
        logic       is_alu;
        logic       is_branch;
        logic       use_imm;
        reg_addr_t  rd;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        word_t      br_offset;
    } exe_t;

    // valid only when the producer writes a nonzero rd
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      is_branch;
        logic      taken;
        logic      writes_rd;
        reg_addr_t rd;
        word_t     data;
    } retire_t;

endpackage

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic reset_o
);

    int edges_q = 0;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset drops right after the last counted rising edge
    always @(posedge clk_o) begin
        if (edges_q < RESET_CYCLES) begin
            edges_q <= edges_q + 1;
        end
    end

    assign reset_o = (edges_q < RESET_CYCLES);

endmodule

`default_nettype wire

// File: writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  sodor_pkg::exe_t      exe_i,
    input  sodor_pkg::fwd_t      alu_i,
    input  sodor_pkg::redirect_t redirect_i,
    output sodor_pkg::fwd_t      mem_fwd_o,
    output sodor_pkg::fwd_t      wr_o,
    output sodor_pkg::retire_t   retire_o
);
    import sodor_pkg::*;

    retire_t ret_d;
    retire_t mem_q;
    retire_t wb_q;

    // one record per executed instruction
    always_comb begin
        ret_d.valid     = exe_i.valid;
        ret_d.pc        = exe_i.pc;
        ret_d.is_branch = exe_i.is_branch;
        ret_d.taken     = redirect_i.taken;
        ret_d.writes_rd = alu_i.valid;
        ret_d.rd        = exe_i.rd;
        ret_d.data      = alu_i.data;
    end

    // memory register, then writeback register
    always_ff @(posedge clk) begin
        mem_q <= ret_d;
        wb_q  <= mem_q;
        if (reset) begin
            mem_q.valid     <= 1'b0;
            mem_q.writes_rd <= 1'b0;
            wb_q.valid      <= 1'b0;
            wb_q.writes_rd  <= 1'b0;
        end
    end

    always_comb begin
        mem_fwd_o.valid = mem_q.valid && mem_q.writes_rd;
        mem_fwd_o.rd    = mem_q.rd;
        mem_fwd_o.data  = mem_q.data;
    end

    // the writeback register feeds the register file write port
    always_comb begin
        wr_o.valid = wb_q.valid && wb_q.writes_rd;
        wr_o.rd    = wb_q.rd;
        wr_o.data  = wb_q.data;
    end

    assign retire_o = wb_q;

endmodule

`default_nettype wire
